/* source/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Reservation-station tag width
`define RSV_ID_W 4

// Core data and address width
`define DATA_W 32

// Global memory address width
`define GMEM_ADDR_W 28

// Byte-wide I/O port
`define IO_DATA_W 8

// Queue depths
`define REQ_DEPTH 4
`define CDB_DEPTH 2

`endif

/* source/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

   // Core opcodes seen by the load/store path and any other code acts as a no-op
   typedef enum logic [7:0] {
      I_NOP    = 8'h00,
      I_LOAD   = 8'h10,
      I_LOADB  = 8'h11,
      I_STORE  = 8'h12,
      I_STOREB = 8'h13,
      I_INPUT  = 8'h20,
      I_OUTPUT = 8'h21
   } opcode_t;

   typedef enum logic [1:0] {
      acc_load,
      acc_store,
      acc_in,
      acc_out
   } access_kind_t;

   typedef struct packed {
      logic [`RSV_ID_W-1:0]    tag;
      access_kind_t            kind;
      logic                    is_byte;
      logic [`GMEM_ADDR_W-1:0] addr;
      logic [`DATA_W-1:0]      data;
   } mem_req_t;

   typedef struct packed {
      logic [`RSV_ID_W-1:0] tag;
      logic [`DATA_W-1:0]   value;
   } cdb_entry_t;

endpackage

`default_nettype wire

/* source/mem_request_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module mem_request_fifo import lsu_pkg::*; #(
   parameter type T_ENTRY = mem_req_t,
   parameter int  DEPTH   = `REQ_DEPTH
) (
   input  wire logic   clk,
   input  wire logic   nrst,
   input  wire logic   i_push,
   input  wire T_ENTRY i_data,
   input  wire logic   i_pop,
   output T_ENTRY      o_data,
   output logic        o_full,
   output logic        o_empty
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   T_ENTRY           mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign o_full  = (count == CNT_W'(DEPTH));
   assign o_empty = (count == '0);
   assign do_push = i_push && !o_full;
   assign do_pop  = i_pop && !o_empty;
   assign o_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Occupancy only moves when exactly one side is active
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* source/mem_issue_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module mem_issue_stage import lsu_pkg::*; (
   input  wire logic                   clk,
   input  wire logic                   nrst,
   input  wire logic                   i_valid,
   input  wire logic [`RSV_ID_W-1:0]   i_rsv_id,
   input  wire opcode_t                i_opcode,
   input  wire logic [`DATA_W-1:0]     i_address,
   input  wire logic [`DATA_W-1:0]     i_data,
   input  wire logic                   i_fifo_full,
   output logic                        o_ready,
   output logic                        o_push,
   output mem_req_t                    o_req
);

   access_kind_t kind;
   logic         is_byte;
   logic         is_mem;
   logic         ready_en;
   logic         pending;
   logic         accept;
   mem_req_t     req_q;

   always_comb begin
      kind    = acc_load;
      is_byte = 1'b0;
      is_mem  = 1'b1;
      case (i_opcode)
         I_LOAD:   kind = acc_load;
         I_LOADB: begin
            kind    = acc_load;
            is_byte = 1'b1;
         end
         I_STORE:  kind = acc_store;
         I_STOREB: begin
            kind    = acc_store;
            is_byte = 1'b1;
         end
         I_INPUT:  kind = acc_in;
         I_OUTPUT: kind = acc_out;
         default:  is_mem = 1'b0;
      endcase
   end

   // Held entry waits here while the queue is full
   assign o_ready = ready_en && !i_fifo_full;
   assign o_push  = pending && !i_fifo_full;
   assign o_req   = req_q;
   assign accept  = i_valid && o_ready;

   always_ff @(posedge clk) begin
      if (nrst) begin
         ready_en <= 1'b0;
         pending  <= 1'b0;
      end else begin
         ready_en <= 1'b1;
         if (accept) begin
            pending <= is_mem;
         end else if (o_push) begin
            pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept && is_mem) begin
         req_q.tag     <= i_rsv_id;
         req_q.kind    <= kind;
         req_q.is_byte <= is_byte;
         req_q.addr    <= i_address[`GMEM_ADDR_W-1:0];
         req_q.data    <= i_data;
      end
   end

endmodule

`default_nettype wire

/* source/memory_management_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module memory_management_unit import lsu_pkg::*; (
   input  wire logic                     clk,
   input  wire logic                     nrst,

   input  wire mem_req_t                 i_req,
   input  wire logic                     i_req_empty,
   output logic                          o_req_pop,

   input  wire logic                     i_cdb_full,
   output logic                          o_cdb_push,
   output cdb_entry_t                    o_cdb_entry,

   output logic [`GMEM_ADDR_W-1:0]       o_gm_awaddr,
   output logic                          o_gm_awvalid,
   input  wire logic                     i_gm_awready,
   output logic [`DATA_W-1:0]            o_gm_wdata,
   output logic [`DATA_W/8-1:0]          o_gm_wstrb,
   output logic                          o_gm_wvalid,
   input  wire logic                     i_gm_wready,

   output logic [`GMEM_ADDR_W-1:0]       o_gm_araddr,
   output logic                          o_gm_arvalid,
   input  wire logic                     i_gm_arready,
   input  wire logic [`DATA_W-1:0]       i_gm_rdata,
   input  wire logic                     i_gm_rvalid,
   output logic                          o_gm_rready,

   output logic [`IO_DATA_W-1:0]         o_io_wdata,
   output logic                          o_io_wvalid,
   input  wire logic                     i_io_wready,
   input  wire logic [`IO_DATA_W-1:0]    i_io_rdata,
   input  wire logic                     i_io_rvalid,
   output logic                          o_io_rready
);

   localparam int STRB_W = `DATA_W / 8;

   typedef enum logic [2:0] {
      st_idle,
      st_wr_addr,
      st_wr_data,
      st_rd_addr,
      st_rd_data,
      st_io_out,
      st_io_in
   } mmu_state_t;

   mmu_state_t               state;
   mmu_state_t               state_n;
   mem_req_t                 req_q;
   logic [`GMEM_ADDR_W-1:0]  word_addr;
   logic [7:0]               rd_byte;
   logic                     rd_take;
   logic                     in_take;

   assign o_req_pop = (state == st_idle) && !i_req_empty;

   // Memory sees word addresses and lanes are picked by strobes
   assign word_addr   = {req_q.addr[`GMEM_ADDR_W-1:2], 2'b00};
   assign o_gm_awaddr = word_addr;
   assign o_gm_araddr = word_addr;

   assign o_gm_awvalid = (state == st_wr_addr);
   assign o_gm_wvalid  = (state == st_wr_data);
   assign o_gm_arvalid = (state == st_rd_addr);
   assign o_io_wvalid  = (state == st_io_out);
   assign o_io_wdata   = req_q.data[`IO_DATA_W-1:0];

   always_comb begin
      if (req_q.is_byte) begin
         o_gm_wdata = {STRB_W{req_q.data[7:0]}};
         o_gm_wstrb = STRB_W'(1) << req_q.addr[1:0];
      end else begin
         o_gm_wdata = req_q.data;
         o_gm_wstrb = '1;
      end
   end

   // Read and input data only taken when the result has somewhere to go
   assign o_gm_rready = (state == st_rd_data) && !i_cdb_full;
   assign o_io_rready = (state == st_io_in) && !i_cdb_full;
   assign rd_take     = i_gm_rvalid && o_gm_rready;
   assign in_take     = i_io_rvalid && o_io_rready;
   assign o_cdb_push  = rd_take || in_take;

   assign rd_byte = i_gm_rdata[8*req_q.addr[1:0] +: 8];

   always_comb begin
      o_cdb_entry.tag = req_q.tag;
      if (state == st_io_in) begin
         o_cdb_entry.value = {{(`DATA_W-`IO_DATA_W){1'b0}}, i_io_rdata};
      end else if (req_q.is_byte) begin
         o_cdb_entry.value = {{(`DATA_W-8){1'b0}}, rd_byte};
      end else begin
         o_cdb_entry.value = i_gm_rdata;
      end
   end

   always_comb begin
      state_n = state;
      case (state)
         st_idle: begin
            if (!i_req_empty) begin
               case (i_req.kind)
                  acc_store: state_n = st_wr_addr;
                  acc_load:  state_n = st_rd_addr;
                  acc_out:   state_n = st_io_out;
                  default:   state_n = st_io_in;
               endcase
            end
         end
         st_wr_addr: begin
            if (i_gm_awready) begin
               state_n = st_wr_data;
            end
         end
         st_wr_data: begin
            if (i_gm_wready) begin
               state_n = st_idle;
            end
         end
         st_rd_addr: begin
            if (i_gm_arready) begin
               state_n = st_rd_data;
            end
         end
         st_rd_data: begin
            if (rd_take) begin
               state_n = st_idle;
            end
         end
         st_io_out: begin
            if (i_io_wready) begin
               state_n = st_idle;
            end
         end
         st_io_in: begin
            if (in_take) begin
               state_n = st_idle;
            end
         end
         default: state_n = st_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         state <= st_idle;
      end else begin
         state <= state_n;
      end
   end

   always_ff @(posedge clk) begin
      if (o_req_pop) begin
         req_q <= i_req;
      end
   end

endmodule

`default_nettype wire

/* source/lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module lsu_top import lsu_pkg::*; (
   input  wire logic                     clk,
   input  wire logic                     nrst,

   input  wire logic                     i_valid,
   input  wire logic [`RSV_ID_W-1:0]     i_rsv_id,
   input  wire opcode_t                  i_opcode,
   input  wire logic [`DATA_W-1:0]       i_address,
   input  wire logic [`DATA_W-1:0]       i_data,
   output logic                          o_ready,

   output logic                          o_cdb_valid,
   output logic [`RSV_ID_W-1:0]          o_cdb_rsv_id,
   output logic [`DATA_W-1:0]            o_cdb_value,
   input  wire logic                     i_cdb_ready,

   output logic [`GMEM_ADDR_W-1:0]       o_gm_awaddr,
   output logic                          o_gm_awvalid,
   input  wire logic                     i_gm_awready,
   output logic [`DATA_W-1:0]            o_gm_wdata,
   output logic [`DATA_W/8-1:0]          o_gm_wstrb,
   output logic                          o_gm_wvalid,
   input  wire logic                     i_gm_wready,
   output logic [`GMEM_ADDR_W-1:0]       o_gm_araddr,
   output logic                          o_gm_arvalid,
   input  wire logic                     i_gm_arready,
   input  wire logic [`DATA_W-1:0]       i_gm_rdata,
   input  wire logic                     i_gm_rvalid,
   output logic                          o_gm_rready,

   output logic [`IO_DATA_W-1:0]         o_io_wdata,
   output logic                          o_io_wvalid,
   input  wire logic                     i_io_wready,
   input  wire logic [`IO_DATA_W-1:0]    i_io_rdata,
   input  wire logic                     i_io_rvalid,
   output logic                          o_io_rready
);

   mem_req_t   issue_req;
   logic       issue_push;
   mem_req_t   req_head;
   logic       req_full;
   logic       req_empty;
   logic       req_pop;
   cdb_entry_t mmu_result;
   logic       cdb_push;
   cdb_entry_t cdb_head;
   logic       cdb_full;
   logic       cdb_empty;
   logic       cdb_pop;

   mem_issue_stage u_issue (
      .clk         (clk),
      .nrst        (nrst),
      .i_valid     (i_valid),
      .i_rsv_id    (i_rsv_id),
      .i_opcode    (i_opcode),
      .i_address   (i_address),
      .i_data      (i_data),
      .i_fifo_full (req_full),
      .o_ready     (o_ready),
      .o_push      (issue_push),
      .o_req       (issue_req)
   );

   mem_request_fifo #(.T_ENTRY(mem_req_t), .DEPTH(`REQ_DEPTH)) u_req_fifo (
      .clk     (clk),
      .nrst    (nrst),
      .i_push  (issue_push),
      .i_data  (issue_req),
      .i_pop   (req_pop),
      .o_data  (req_head),
      .o_full  (req_full),
      .o_empty (req_empty)
   );

   memory_management_unit u_mmu (
      .clk          (clk),
      .nrst         (nrst),
      .i_req        (req_head),
      .i_req_empty  (req_empty),
      .o_req_pop    (req_pop),
      .i_cdb_full   (cdb_full),
      .o_cdb_push   (cdb_push),
      .o_cdb_entry  (mmu_result),
      .o_gm_awaddr  (o_gm_awaddr),
      .o_gm_awvalid (o_gm_awvalid),
      .i_gm_awready (i_gm_awready),
      .o_gm_wdata   (o_gm_wdata),
      .o_gm_wstrb   (o_gm_wstrb),
      .o_gm_wvalid  (o_gm_wvalid),
      .i_gm_wready  (i_gm_wready),
      .o_gm_araddr  (o_gm_araddr),
      .o_gm_arvalid (o_gm_arvalid),
      .i_gm_arready (i_gm_arready),
      .i_gm_rdata   (i_gm_rdata),
      .i_gm_rvalid  (i_gm_rvalid),
      .o_gm_rready  (o_gm_rready),
      .o_io_wdata   (o_io_wdata),
      .o_io_wvalid  (o_io_wvalid),
      .i_io_wready  (i_io_wready),
      .i_io_rdata   (i_io_rdata),
      .i_io_rvalid  (i_io_rvalid),
      .o_io_rready  (o_io_rready)
   );

   mem_request_fifo #(.T_ENTRY(cdb_entry_t), .DEPTH(`CDB_DEPTH)) u_cdb_fifo (
      .clk     (clk),
      .nrst    (nrst),
      .i_push  (cdb_push),
      .i_data  (mmu_result),
      .i_pop   (cdb_pop),
      .o_data  (cdb_head),
      .o_full  (cdb_full),
      .o_empty (cdb_empty)
   );

   // Result bus is served straight from the queue head
   assign o_cdb_valid  = !cdb_empty;
   assign o_cdb_rsv_id = cdb_head.tag;
   assign o_cdb_value  = cdb_head.value;
   assign cdb_pop      = o_cdb_valid && i_cdb_ready;

endmodule

`default_nettype wire

/* testbench/tb_gmem_model.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module tb_gmem_model #(
   parameter logic [31:0] SEED = 32'habe1
) (
   input  wire logic                    clk,
   input  wire logic [`GMEM_ADDR_W-1:0] i_awaddr,
   input  wire logic                    i_awvalid,
   output logic                         o_awready,
   input  wire logic [`DATA_W-1:0]      i_wdata,
   input  wire logic [`DATA_W/8-1:0]    i_wstrb,
   input  wire logic                    i_wvalid,
   output logic                         o_wready,
   input  wire logic [`GMEM_ADDR_W-1:0] i_araddr,
   input  wire logic                    i_arvalid,
   output logic                         o_arready,
   output logic [`DATA_W-1:0]           o_rdata,
   output logic                         o_rvalid,
   input  wire logic                    i_rready
);

   logic [`DATA_W-1:0]      mem [256];
   logic [`GMEM_ADDR_W-1:0] wr_addr;
   logic [`GMEM_ADDR_W-1:0] rd_addr;
   logic                    ar_done;
   logic                    r_done;
   integer                  seed;

   function automatic logic draw_ready();
      return ($random(seed) & 32'h3) != 0;
   endfunction

   // Only lanes with a strobe set are touched
   task automatic write_lanes(input logic [7:0] idx, input logic [31:0] data,
                              input logic [3:0] strb);
      for (int lane = 0; lane < 4; lane++) begin
         if (strb[lane]) begin
            mem[idx][8*lane +: 8] = data[8*lane +: 8];
         end
      end
   endtask

   initial begin
      seed      = SEED;
      wr_addr   = '0;
      rd_addr   = '0;
      o_awready = 1'b0;
      o_wready  = 1'b0;
      o_arready = 1'b0;
      o_rvalid  = 1'b0;
      o_rdata   = '0;
      foreach (mem[i]) begin
         mem[i] = '0;
      end
      forever begin
         // Handshakes seen here complete on the coming rising edge
         @(negedge clk);
         ar_done = i_arvalid && o_arready;
         r_done  = o_rvalid && i_rready;
         if (i_awvalid && o_awready) begin
            wr_addr = i_awaddr;
         end
         if (i_wvalid && o_wready) begin
            write_lanes(wr_addr[9:2], i_wdata, i_wstrb);
         end
         if (ar_done) begin
            rd_addr = i_araddr;
         end
         @(posedge clk);
         #1;
         if (r_done) begin
            o_rvalid = 1'b0;
         end
         if (ar_done) begin
            o_rvalid = 1'b1;
            o_rdata  = mem[rd_addr[9:2]];
         end
         o_awready = draw_ready();
         o_wready  = draw_ready();
         o_arready = draw_ready();
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_lsu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lsu_params.svh"

module tb_lsu_top import lsu_pkg::*; ();

   localparam int NUM_CASES     = 16;
   localparam int CASE_WORDS    = 6 * NUM_CASES;
   localparam int REQ_TIMEOUT   = 200;
   localparam int DRAIN_TIMEOUT = 2000;
   localparam int STALL_LOADS   = 12;
   localparam int STALL_HOLD    = 40;
   localparam int STALL_BASE    = 32'h100;

   logic                    clk = 1'b0;
   logic                    nrst;
   logic                    i_valid;
   logic [`RSV_ID_W-1:0]    i_rsv_id;
   opcode_t                 i_opcode;
   logic [`DATA_W-1:0]      i_address;
   logic [`DATA_W-1:0]      i_data;
   logic                    o_ready;
   logic                    o_cdb_valid;
   logic [`RSV_ID_W-1:0]    o_cdb_rsv_id;
   logic [`DATA_W-1:0]      o_cdb_value;
   logic                    i_cdb_ready;
   logic [`GMEM_ADDR_W-1:0] o_gm_awaddr;
   logic                    o_gm_awvalid;
   logic                    i_gm_awready;
   logic [`DATA_W-1:0]      o_gm_wdata;
   logic [`DATA_W/8-1:0]    o_gm_wstrb;
   logic                    o_gm_wvalid;
   logic                    i_gm_wready;
   logic [`GMEM_ADDR_W-1:0] o_gm_araddr;
   logic                    o_gm_arvalid;
   logic                    i_gm_arready;
   logic [`DATA_W-1:0]      i_gm_rdata;
   logic                    i_gm_rvalid;
   logic                    o_gm_rready;
   logic [`IO_DATA_W-1:0]   o_io_wdata;
   logic                    o_io_wvalid;
   logic                    i_io_wready;
   logic [`IO_DATA_W-1:0]   i_io_rdata;
   logic                    i_io_rvalid;
   logic                    o_io_rready;

   logic [31:0]             cases [CASE_WORDS];
   logic [`RSV_ID_W-1:0]    exp_tag [$];
   logic [`DATA_W-1:0]      exp_value [$];
   logic [`IO_DATA_W-1:0]   in_bytes [$];
   logic [`IO_DATA_W-1:0]   out_bytes [$];
   logic                    hold_cdb;
   logic                    in_done;
   integer                  seed;

   always #4 clk = ~clk;

   lsu_top dut0 (
      .clk          (clk),
      .nrst         (nrst),
      .i_valid      (i_valid),
      .i_rsv_id     (i_rsv_id),
      .i_opcode     (i_opcode),
      .i_address    (i_address),
      .i_data       (i_data),
      .o_ready      (o_ready),
      .o_cdb_valid  (o_cdb_valid),
      .o_cdb_rsv_id (o_cdb_rsv_id),
      .o_cdb_value  (o_cdb_value),
      .i_cdb_ready  (i_cdb_ready),
      .o_gm_awaddr  (o_gm_awaddr),
      .o_gm_awvalid (o_gm_awvalid),
      .i_gm_awready (i_gm_awready),
      .o_gm_wdata   (o_gm_wdata),
      .o_gm_wstrb   (o_gm_wstrb),
      .o_gm_wvalid  (o_gm_wvalid),
      .i_gm_wready  (i_gm_wready),
      .o_gm_araddr  (o_gm_araddr),
      .o_gm_arvalid (o_gm_arvalid),
      .i_gm_arready (i_gm_arready),
      .i_gm_rdata   (i_gm_rdata),
      .i_gm_rvalid  (i_gm_rvalid),
      .o_gm_rready  (o_gm_rready),
      .o_io_wdata   (o_io_wdata),
      .o_io_wvalid  (o_io_wvalid),
      .i_io_wready  (i_io_wready),
      .i_io_rdata   (i_io_rdata),
      .i_io_rvalid  (i_io_rvalid),
      .o_io_rready  (o_io_rready)
   );

   tb_gmem_model #(.SEED(32'habe1)) u_gmem (
      .clk       (clk),
      .i_awaddr  (o_gm_awaddr),
      .i_awvalid (o_gm_awvalid),
      .o_awready (i_gm_awready),
      .i_wdata   (o_gm_wdata),
      .i_wstrb   (o_gm_wstrb),
      .i_wvalid  (o_gm_wvalid),
      .o_wready  (i_gm_wready),
      .i_araddr  (o_gm_araddr),
      .i_arvalid (o_gm_arvalid),
      .o_arready (i_gm_arready),
      .o_rdata   (i_gm_rdata),
      .o_rvalid  (i_gm_rvalid),
      .i_rready  (o_gm_rready)
   );

   function automatic logic draw_ready();
      return ($random(seed) & 32'h3) != 0;
   endfunction

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic report_error(input string what);
      $display("ERROR: %s", what);
      abort_run();
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
         abort_run();
      end
   endtask

   task automatic check_reset_outputs();
      @(negedge clk);
      check_value("o_ready", o_ready, 0);
      check_value("o_cdb_valid", o_cdb_valid, 0);
      check_value("o_gm_awvalid", o_gm_awvalid, 0);
      check_value("o_gm_wvalid", o_gm_wvalid, 0);
      check_value("o_gm_arvalid", o_gm_arvalid, 0);
      check_value("o_gm_rready", o_gm_rready, 0);
      check_value("o_io_wvalid", o_io_wvalid, 0);
      check_value("o_io_rready", o_io_rready, 0);
      @(posedge clk);
      #1;
   endtask

   // Holds the request until o_ready is seen with expectations queued up front
   task automatic send_request(input logic [7:0] op, input logic [3:0] tag,
                               input logic [31:0] addr, input logic [31:0] data,
                               input logic has_result, input logic [31:0] expected);
      int   cycles;
      logic taken;
      cycles = 0;
      taken  = 1'b0;
      if (has_result) begin
         exp_tag.push_back(tag);
         exp_value.push_back(expected);
      end
      if (op == I_INPUT) begin
         in_bytes.push_back(data[7:0]);
      end
      if (op == I_OUTPUT) begin
         out_bytes.push_back(data[7:0]);
      end
      i_valid   = 1'b1;
      i_rsv_id  = tag;
      i_opcode  = opcode_t'(op);
      i_address = addr;
      i_data    = data;
      while (!taken) begin
         @(negedge clk);
         taken = o_ready;
         @(posedge clk);
         #1;
         cycles++;
         if (!taken && cycles >= REQ_TIMEOUT) begin
            report_error("request was not accepted before the timeout");
         end
      end
      i_valid = 1'b0;
   endtask

   task automatic wait_for_drain();
      int cycles;
      cycles = 0;
      while (exp_tag.size() != 0 || in_bytes.size() != 0 || out_bytes.size() != 0) begin
         @(posedge clk);
         #1;
         cycles++;
         if (cycles >= DRAIN_TIMEOUT) begin
            report_error("expected results did not all arrive before the timeout");
         end
      end
   endtask

   task automatic run_case_file();
      for (int n = 0; n < NUM_CASES; n++) begin
         send_request(cases[6*n][7:0], cases[6*n+1][3:0], cases[6*n+2], cases[6*n+3],
                      cases[6*n+4][0], cases[6*n+5]);
      end
      wait_for_drain();
   endtask

   task automatic run_stall_test();
      int   k;
      int   low_cycles;
      logic dropped;
      for (k = 0; k < STALL_LOADS; k++) begin
         send_request(I_STORE, k[3:0], STALL_BASE + 4*k, 32'h5a5a_0000 + k, 1'b0, '0);
      end
      @(negedge clk);
      hold_cdb   = 1'b1;
      dropped    = 1'b0;
      low_cycles = 0;
      k          = 0;
      @(posedge clk);
      #1;
      // Loads keep coming until the stalled pipeline stops taking them for good
      while (!dropped && k < STALL_LOADS) begin
         i_valid   = 1'b1;
         i_rsv_id  = k[3:0];
         i_opcode  = I_LOAD;
         i_address = STALL_BASE + 4*k;
         i_data    = '0;
         @(negedge clk);
         if (o_ready) begin
            exp_tag.push_back(k[3:0]);
            exp_value.push_back(32'h5a5a_0000 + k);
            k++;
            low_cycles = 0;
         end else begin
            low_cycles++;
            dropped = (low_cycles >= STALL_HOLD);
         end
         @(posedge clk);
         #1;
      end
      i_valid = 1'b0;
      if (!dropped) begin
         report_error("o_ready stayed high while the result bus was held");
      end
      @(negedge clk);
      hold_cdb = 1'b0;
      @(posedge clk);
      #1;
      while (k < STALL_LOADS) begin
         send_request(I_LOAD, k[3:0], STALL_BASE + 4*k, '0, 1'b1, 32'h5a5a_0000 + k);
         k++;
      end
      wait_for_drain();
   endtask

   // Random back-pressure on the result bus and the I/O write side
   initial begin
      forever begin
         @(posedge clk);
         #1;
         i_cdb_ready = hold_cdb ? 1'b0 : draw_ready();
         i_io_wready = draw_ready();
      end
   end

   initial begin
      forever begin
         @(negedge clk);
         if (!nrst && o_cdb_valid && i_cdb_ready) begin
            if (exp_tag.size() == 0) begin
               report_error("result bus delivered a result that no request asked for");
            end else begin
               check_value("o_cdb_rsv_id", o_cdb_rsv_id, exp_tag[0]);
               check_value("o_cdb_value", o_cdb_value, exp_value[0]);
               exp_tag.delete(0);
               exp_value.delete(0);
            end
         end
      end
   end

   // I/O input side serves queued bytes and the output side checks them
   initial begin
      forever begin
         @(negedge clk);
         in_done = !nrst && i_io_rvalid && o_io_rready;
         if (!nrst && o_io_wvalid && i_io_wready) begin
            if (out_bytes.size() == 0) begin
               report_error("I/O write port fired with no output request pending");
            end else begin
               check_value("o_io_wdata", o_io_wdata, out_bytes[0]);
               out_bytes.delete(0);
            end
         end
         @(posedge clk);
         #1;
         if (in_done) begin
            in_bytes.delete(0);
         end
         i_io_rvalid = (in_bytes.size() != 0);
         i_io_rdata  = i_io_rvalid ? in_bytes[0] : '0;
      end
   end

   initial begin
      seed        = 32'habe1;
      hold_cdb    = 1'b0;
      in_done     = 1'b0;
      nrst        = 1'b1;
      i_valid     = 1'b0;
      i_rsv_id    = '0;
      i_opcode    = I_NOP;
      i_address   = '0;
      i_data      = '0;
      i_cdb_ready = 1'b0;
      i_io_wready = 1'b0;
      i_io_rvalid = 1'b0;
      i_io_rdata  = '0;
      $readmemh("testbench/lsu_cases.txt", cases);
      repeat (2) @(posedge clk);
      #1;
      nrst = 1'b0;
      check_reset_outputs();
      run_case_file();
      run_stall_test();
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

/* testbench/lsu_cases.txt */
// opcode tag address data has_result expected
// opcodes: 00 nop, 10 load, 11 loadb, 12 store, 13 storeb, 20 input, 21 output
12 1 00000010 deadbeef 0 00000000
10 2 00000010 00000000 1 deadbeef
13 3 00000011 000000a5 0 00000000
10 4 00000010 00000000 1 deada5ef
11 5 00000011 00000000 1 000000a5
11 6 00000012 00000000 1 000000ad
21 7 00000000 00001234 0 00000000
20 8 00000000 00ab005c 1 0000005c
00 9 00000020 11111111 0 00000000
13 a 00000020 000000ff 0 00000000
12 b 00000024 cafef00d 0 00000000
11 c 00000020 00000000 1 000000ff
10 d 00000024 00000000 1 cafef00d
20 e 00000000 000000c3 1 000000c3
10 f 00000020 00000000 1 000000ff
21 0 00000000 000000e7 0 00000000

/* filelist.f */
+incdir+source
source/lsu_pkg.sv
source/mem_request_fifo.sv
source/mem_issue_stage.sv
source/memory_management_unit.sv
source/lsu_top.sv
testbench/tb_gmem_model.sv
testbench/tb_lsu_top.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/mem_request_fifo.sv
      - source/mem_issue_stage.sv
      - source/memory_management_unit.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_gmem_model.sv
      - testbench/tb_lsu_top.sv
